// File: design/agen_pkg.sv
// ##########################################################
// shared codes and payload structs for address generation
// segment limits are not modeled and no SIB byte is carried
// ##########################################################
package agen_pkg;

    // operand source codes
    typedef logic [2:0] op_src_t;

    localparam op_src_t SRC_NONE  = 3'd0;
    localparam op_src_t SRC_REG   = 3'd1;
    localparam op_src_t SRC_SEG   = 3'd2;
    localparam op_src_t SRC_MMX   = 3'd3;
    localparam op_src_t SRC_MODRM = 3'd4;
    localparam op_src_t SRC_IMM   = 3'd5;
    localparam op_src_t SRC_MEM   = 3'd6;
    localparam op_src_t SRC_SYS   = 3'd7;

    // operand size codes, anything else reads as zero
    typedef logic [2:0] op_size_t;

    localparam op_size_t SIZE_BYTE  = 3'd1;
    localparam op_size_t SIZE_WORD  = 3'd2;
    localparam op_size_t SIZE_DWORD = 3'd3;
    localparam op_size_t SIZE_MMX   = 3'd5;

    // segment register indices, 6 and 7 read as zero
    typedef logic [2:0] seg_idx_t;

    localparam seg_idx_t SEG_ES = 3'd0;
    localparam seg_idx_t SEG_CS = 3'd1;
    localparam seg_idx_t SEG_SS = 3'd2;
    localparam seg_idx_t SEG_DS = 3'd3;
    localparam seg_idx_t SEG_FS = 3'd4;
    localparam seg_idx_t SEG_GS = 3'd5;

    // real mode style base, selector times 16
    localparam int SEG_SHIFT = 4;

    // string pointer registers
    localparam logic [2:0] REG_ESI = 3'd6;
    localparam logic [2:0] REG_EDI = 3'd7;

    // gpr[0] is EAX up to gpr[7] as EDI
    typedef struct packed {
        logic [7:0][31:0] gpr;
        logic [5:0][15:0] seg;
        logic [7:0][63:0] mmx;
    } arch_regs_t;

    typedef struct packed {
        op_src_t    src;
        logic [2:0] reg_idx;
    } operand_sel_t;

    typedef struct packed {
        op_size_t     size;
        operand_sel_t op0;
        operand_sel_t op1;
        logic [7:0]   modrm;
        logic [31:0]  disp;
        logic [47:0]  imm;
        seg_idx_t     seg_override;
        logic         seg_override_valid;
        logic [3:0]   alu_op;
        logic [1:0]   stack_op;
        logic [31:0]  stack_address;
        logic [31:0]  pc;
        logic [15:0]  opcode;
    } agen_req_t;

    // size selected view of each register index
    typedef logic [7:0][63:0] sized_regs_t;

    typedef struct packed {
        logic [63:0] value;
        logic        is_address;
        logic        is_reg;
    } operand_t;

    typedef struct packed {
        op_size_t    size;
        logic [63:0] op0;
        logic [63:0] op1;
        logic [2:0]  op0_reg;
        logic [2:0]  op1_reg;
        logic        op0_is_address;
        logic        op0_is_reg;
        logic        op0_is_segment;
        logic        op0_is_mmx;
        logic        op1_is_reg;
        logic        op1_is_address;
        logic [47:0] imm;
        logic [3:0]  alu_op;
        logic [1:0]  stack_op;
        logic [31:0] stack_address;
        logic [31:0] pc;
        logic [15:0] opcode;
        logic        to_sys_controller;
    } agen_resp_t;

endpackage

// File: design/reg_size_selector.sv
// ##########################################################
// byte size maps indices 4..7 to AH, CH, DH, BH
// unknown size codes give all zero views
// ##########################################################
`timescale 1ns/1ns

module reg_size_selector
    import agen_pkg::*;
(
    input  op_size_t    size,
    input  arch_regs_t  regs,
    output sized_regs_t views
);

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            case (size)
                SIZE_BYTE: begin
                    // upper four indices are the high bytes of EAX..EBX
                    if (i < 4) begin
                        views[i] = {56'd0, regs.gpr[i][7:0]};
                    end else begin
                        views[i] = {56'd0, regs.gpr[i % 4][15:8]};
                    end
                end
                SIZE_WORD: begin
                    views[i] = {48'd0, regs.gpr[i][15:0]};
                end
                SIZE_DWORD: begin
                    views[i] = {32'd0, regs.gpr[i]};
                end
                SIZE_MMX: begin
                    views[i] = regs.mmx[i];
                end
                default: begin
                    views[i] = 64'd0;
                end
            endcase
        end
    end

endmodule

// File: design/operand_generator.sv
// ##########################################################
// mod r/m uses 32-bit forms only, rm 100 takes ESP as base
// default segment is DS, no SS default for EBP
// addresses wrap at 32 bits and are zero extended
// ##########################################################
`timescale 1ns/1ns

module operand_generator
    import agen_pkg::*;
#(
    parameter bit STRING_DEST = 1'b0
) (
    input  operand_sel_t sel,
    input  agen_req_t    req,
    input  arch_regs_t   regs,
    input  sized_regs_t  views,
    output operand_t     operand
);

    function automatic logic [15:0] seg_read(input arch_regs_t r, input seg_idx_t idx);
        logic [15:0] selector;
        case (idx)
            SEG_ES: selector = r.seg[SEG_ES];
            SEG_CS: selector = r.seg[SEG_CS];
            SEG_SS: selector = r.seg[SEG_SS];
            SEG_DS: selector = r.seg[SEG_DS];
            SEG_FS: selector = r.seg[SEG_FS];
            SEG_GS: selector = r.seg[SEG_GS];
            default: selector = 16'd0;
        endcase
        return selector;
    endfunction

    function automatic logic [31:0] seg_base(input logic [15:0] selector);
        logic [31:0] base;
        base = {16'd0, selector} << SEG_SHIFT;
        return base;
    endfunction

    logic [1:0]  mod_bits;
    logic [2:0]  rm;
    logic        modrm_is_mem;
    logic        disp_only;
    seg_idx_t    data_seg;
    logic [31:0] data_seg_base;
    logic [31:0] modrm_base;
    logic [31:0] modrm_disp;
    logic [31:0] modrm_addr;
    logic [31:0] string_addr;

    assign mod_bits     = req.modrm[7:6];
    assign rm           = req.modrm[2:0];
    assign modrm_is_mem = (mod_bits != 2'b11);
    assign disp_only    = (mod_bits == 2'b00) && (rm == 3'b101);

    // override wins over the DS default
    assign data_seg      = req.seg_override_valid ? req.seg_override : SEG_DS;
    assign data_seg_base = seg_base(seg_read(regs, data_seg));

    always_comb begin
        case (mod_bits)
            2'b00:   modrm_disp = disp_only ? req.disp : 32'd0;
            2'b01:   modrm_disp = {{24{req.disp[7]}}, req.disp[7:0]};
            2'b10:   modrm_disp = req.disp;
            default: modrm_disp = 32'd0;
        endcase
    end

    assign modrm_base = disp_only ? 32'd0 : regs.gpr[rm];
    assign modrm_addr = data_seg_base + modrm_base + modrm_disp;

    // destination string is always ES:EDI, source honours the override
    assign string_addr = STRING_DEST
                       ? seg_base(seg_read(regs, SEG_ES)) + regs.gpr[REG_EDI]
                       : data_seg_base + regs.gpr[REG_ESI];

    always_comb begin
        case (sel.src)
            SRC_REG: begin
                operand.value = views[sel.reg_idx];
            end
            SRC_SEG: begin
                operand.value = {48'd0, seg_read(regs, sel.reg_idx)};
            end
            SRC_MMX: begin
                operand.value = regs.mmx[sel.reg_idx];
            end
            SRC_MODRM: begin
                operand.value = modrm_is_mem ? {32'd0, modrm_addr} : views[rm];
            end
            SRC_IMM: begin
                operand.value = {16'd0, req.imm};
            end
            SRC_MEM: begin
                operand.value = {32'd0, string_addr};
            end
            SRC_NONE, SRC_SYS: begin
                operand.value = 64'd0;
            end
        endcase
    end

    assign operand.is_address = (sel.src == SRC_MEM) ||
                                ((sel.src == SRC_MODRM) && modrm_is_mem);
    assign operand.is_reg     = (sel.src == SRC_REG) ||
                                ((sel.src == SRC_MODRM) && !modrm_is_mem);

endmodule

// File: design/agen_stage.sv
// ##########################################################
// single entry output register, no bubble on back to back
// flush empties the entry and blocks new input that cycle
// ##########################################################
`timescale 1ns/1ns

module agen_stage
    import agen_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  logic       in_valid,
    output logic       in_ready,
    input  agen_resp_t in_data,
    output logic       out_valid,
    input  logic       out_ready,
    output agen_resp_t out_data
);

    logic load;

    // room when empty or when the held item leaves this cycle
    assign in_ready = (!out_valid || out_ready) && !flush;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

// File: design/address_generation_top.sv
// ##########################################################
// r_req and r_regs must stay stable while r_valid waits
// pops replace operand 1 with the stack address
// ##########################################################
`timescale 1ns/1ns

module address_generation_top
    import agen_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  logic       r_valid,
    output logic       r_ready,
    input  agen_req_t  r_req,
    input  arch_regs_t r_regs,
    output logic       a_valid,
    input  logic       a_ready,
    output agen_resp_t a_resp
);

    sized_regs_t  views;
    operand_sel_t op_sel [2];
    operand_t     op_res [2];
    agen_resp_t   resp;
    logic         is_pop;

    reg_size_selector reg_size_selector_inst (
        .size  (r_req.size),
        .regs  (r_regs),
        .views (views)
    );

    assign op_sel[0] = r_req.op0;
    assign op_sel[1] = r_req.op1;

    // slot 0 is the string destination
    for (genvar gi = 0; gi < 2; gi++) begin : gen_operand
        operand_generator #(
            .STRING_DEST ((gi == 0) ? 1'b1 : 1'b0)
        ) operand_generator_inst (
            .sel     (op_sel[gi]),
            .req     (r_req),
            .regs    (r_regs),
            .views   (views),
            .operand (op_res[gi])
        );
    end

    assign is_pop = r_req.stack_op[1];

    always_comb begin
        resp                   = '0;
        resp.size              = r_req.size;
        resp.op0               = op_res[0].value;
        resp.op1               = is_pop ? {32'd0, r_req.stack_address} : op_res[1].value;
        resp.op0_reg           = r_req.op0.reg_idx;
        resp.op1_reg           = r_req.op1.reg_idx;
        resp.op0_is_address    = op_res[0].is_address;
        resp.op0_is_reg        = op_res[0].is_reg;
        resp.op0_is_segment    = (r_req.op0.src == SRC_SEG);
        resp.op0_is_mmx        = (r_req.size == SIZE_MMX);
        resp.op1_is_reg        = op_res[1].is_reg;
        resp.op1_is_address    = op_res[1].is_address || is_pop;
        resp.imm               = r_req.imm;
        resp.alu_op            = r_req.alu_op;
        resp.stack_op          = r_req.stack_op;
        resp.stack_address     = r_req.stack_address;
        resp.pc                = r_req.pc;
        resp.opcode            = r_req.opcode;
        // system instructions are routed by the operand 0 source
        resp.to_sys_controller = (r_req.op0.src == SRC_SYS);
    end

    agen_stage agen_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .in_data   (resp),
        .out_valid (a_valid),
        .out_ready (a_ready),
        .out_data  (a_resp)
    );

endmodule

// File: testbench/agen_ref.svh
// ##########################################################
// expected response of the address generation stage
// 32-bit mod r/m forms only, no SIB, DS default segment
// ##########################################################
`ifndef AGEN_REF_SVH
`define AGEN_REF_SVH

// indices 6 and 7 have no segment register
function automatic logic [31:0] ref_seg_base(input arch_regs_t regs, input logic [2:0] idx);
    logic [31:0] base;
    base = 32'd0;
    if (idx < 3'd6) begin
        base = {12'd0, regs.seg[idx], 4'd0};
    end
    return base;
endfunction

function automatic logic [63:0] ref_view(input op_size_t size, input arch_regs_t regs,
                                         input logic [2:0] idx);
    logic [63:0] view;
    view = 64'd0;
    if (size == SIZE_BYTE && idx < 3'd4) begin
        view[7:0] = regs.gpr[idx][7:0];
    end else if (size == SIZE_BYTE) begin
        // AH, CH, DH, BH
        view[7:0] = regs.gpr[idx - 3'd4][15:8];
    end else if (size == SIZE_WORD) begin
        view[15:0] = regs.gpr[idx][15:0];
    end else if (size == SIZE_DWORD) begin
        view[31:0] = regs.gpr[idx];
    end else if (size == SIZE_MMX) begin
        view = regs.mmx[idx];
    end
    return view;
endfunction

function automatic operand_t ref_operand(input operand_sel_t sel, input agen_req_t req,
                                         input arch_regs_t regs, input bit dest);
    operand_t    op;
    logic [2:0]  rm;
    logic [2:0]  seg;
    logic [31:0] base;
    logic [31:0] disp;
    rm  = req.modrm[2:0];
    seg = req.seg_override_valid ? req.seg_override : 3'd3;
    op  = '0;
    if (sel.src == SRC_REG) begin
        op.value  = ref_view(req.size, regs, sel.reg_idx);
        op.is_reg = 1'b1;
    end else if (sel.src == SRC_SEG && sel.reg_idx < 3'd6) begin
        op.value = {48'd0, regs.seg[sel.reg_idx]};
    end else if (sel.src == SRC_MMX) begin
        op.value = regs.mmx[sel.reg_idx];
    end else if (sel.src == SRC_IMM) begin
        op.value = {16'd0, req.imm};
    end else if (sel.src == SRC_MEM) begin
        // ES:EDI for the destination, DS or override:ESI for the source
        base = dest ? ref_seg_base(regs, 3'd0) + regs.gpr[7] : ref_seg_base(regs, seg) + regs.gpr[6];
        op.value      = {32'd0, base};
        op.is_address = 1'b1;
    end else if (sel.src == SRC_MODRM && req.modrm[7:6] == 2'b11) begin
        op.value  = ref_view(req.size, regs, rm);
        op.is_reg = 1'b1;
    end else if (sel.src == SRC_MODRM) begin
        base = regs.gpr[rm];
        disp = 32'd0;
        if (req.modrm[7:6] == 2'b01) begin
            disp = {{24{req.disp[7]}}, req.disp[7:0]};
        end else if (req.modrm[7:6] == 2'b10 || rm == 3'b101) begin
            disp = req.disp;
        end
        if (req.modrm[7:6] == 2'b00 && rm == 3'b101) begin
            base = 32'd0;
        end
        op.value      = {32'd0, ref_seg_base(regs, seg) + base + disp};
        op.is_address = 1'b1;
    end
    return op;
endfunction

function automatic agen_resp_t ref_response(input agen_req_t req, input arch_regs_t regs);
    agen_resp_t r;
    operand_t   o0;
    operand_t   o1;
    o0 = ref_operand(req.op0, req, regs, 1'b1);
    o1 = ref_operand(req.op1, req, regs, 1'b0);
    r  = '0;
    r.size              = req.size;
    r.op0               = o0.value;
    r.op1               = req.stack_op[1] ? {32'd0, req.stack_address} : o1.value;
    r.op0_reg           = req.op0.reg_idx;
    r.op1_reg           = req.op1.reg_idx;
    r.op0_is_address    = o0.is_address;
    r.op0_is_reg        = o0.is_reg;
    r.op0_is_segment    = (req.op0.src == SRC_SEG);
    r.op0_is_mmx        = (req.size == SIZE_MMX);
    r.op1_is_reg        = o1.is_reg;
    r.op1_is_address    = o1.is_address || req.stack_op[1];
    r.imm               = req.imm;
    r.alu_op            = req.alu_op;
    r.stack_op          = req.stack_op;
    r.stack_address     = req.stack_address;
    r.pc                = req.pc;
    r.opcode            = req.opcode;
    r.to_sys_controller = (req.op0.src == SRC_SYS);
    return r;
endfunction

`endif

// File: testbench/tb_address_generation.sv
// ##########################################################
// random and directed traffic against a reference model
// a_ready is held low whenever flush hits a held item
// ##########################################################
`timescale 1ns/1ns

module tb_address_generation
    import agen_pkg::*;
();

    localparam int TIMEOUT = 100;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       flush;
    logic       r_valid;
    logic       r_ready;
    agen_req_t  r_req;
    arch_regs_t r_regs;
    logic       a_valid;
    logic       a_ready;
    agen_resp_t a_resp;

    logic [31:0] lcg_state = 32'h7bcd;
    bit          random_ready = 1'b0;
    agen_resp_t  expected_q[$];
    agen_resp_t  held_resp = '0;
    bit          held_valid = 1'b0;
    bit          accepted_last = 1'b0;
    bit          flushed_last = 1'b0;
    int          checked = 0;

    `include "agen_ref.svh"

    address_generation_top address_generation_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_req   (r_req),
        .r_regs  (r_regs),
        .a_valid (a_valid),
        .a_ready (a_ready),
        .a_resp  (a_resp)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_values(input logic [319:0] actual, input logic [319:0] expected,
                                  input string what);
        if (actual !== expected) begin
            $display("error at %0t ns: %s got %h expected %h", $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("Verification failed");
        $fatal(1, "timeout");
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        logic [31:0] rnd;
        @(posedge clk);
        #1;
        if (random_ready) begin
            rnd = next_rand();
            a_ready = rnd[20];
        end
    endtask

    function automatic arch_regs_t random_regs();
        logic [$bits(arch_regs_t)-1:0] bits;
        for (int i = 0; i < $bits(arch_regs_t) / 32; i++) begin
            bits[i*32 +: 32] = next_rand();
        end
        return bits;
    endfunction

    function automatic agen_req_t random_req();
        logic [255:0] bits;
        for (int i = 0; i < 8; i++) begin
            bits[i*32 +: 32] = next_rand();
        end
        return bits[$bits(agen_req_t)-1:0];
    endfunction

    // holds the request until r_ready, returns just after the accepting edge
    task automatic send_req(input agen_req_t req, input arch_regs_t regs);
        int waited;
        r_req   = req;
        r_regs  = regs;
        r_valid = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!r_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_timeout("r_ready");
            end
            next_cycle();
            @(negedge clk);
        end
        next_cycle();
    endtask

    task automatic send_modrm(input logic [7:0] modrm, input op_size_t size, input bit ovr);
        agen_req_t req;
        req = random_req();
        req.op0.src            = SRC_MODRM;
        req.op1.src            = SRC_MODRM;
        req.modrm              = modrm;
        req.size               = size;
        req.seg_override_valid = ovr;
        req.stack_op           = 2'b00;
        // negative byte displacement for mod 01
        req.disp[7]            = 1'b1;
        send_req(req, random_regs());
    endtask

    // sampled mid-cycle, where every input and output is settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (accepted_last) begin
                compare_values(320'(a_valid), 320'(1), "a_valid one cycle after accept");
            end
            if (flushed_last) begin
                compare_values(320'(a_valid), 320'(0), "a_valid after flush");
            end
            if (!a_valid && !flush) begin
                compare_values(320'(r_ready), 320'(1), "r_ready while empty");
            end
            if (held_valid) begin
                compare_values(320'(a_valid), 320'(1), "a_valid under back-pressure");
                compare_values(320'(a_resp), 320'(held_resp), "a_resp under back-pressure");
            end
            if (flush) begin
                if (a_valid && expected_q.size() > 0) begin
                    void'(expected_q.pop_front());
                end
            end else if (a_valid && a_ready) begin
                if (expected_q.size() == 0) begin
                    $display("a response left the DUT with no request pending");
                    $display("Verification failed");
                    $fatal(1, "unexpected response");
                end else begin
                    compare_values(320'(a_resp), 320'(expected_q.pop_front()), "a_resp");
                    checked++;
                end
            end
            held_valid    = a_valid && !a_ready && !flush;
            held_resp     = a_resp;
            accepted_last = r_valid && r_ready;
            flushed_last  = flush;
            if (r_valid && r_ready) begin
                expected_q.push_back(ref_response(r_req, r_regs));
            end
        end
    end

    initial begin
        agen_req_t  req;
        arch_regs_t regs;
        int         waited;
        rst_n   = 1'b0;
        flush   = 1'b0;
        r_valid = 1'b0;
        r_req   = '0;
        r_regs  = '0;
        a_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        compare_values(320'(a_valid), 320'(0), "a_valid after reset");
        compare_values(320'(r_ready), 320'(1), "r_ready after reset");
        next_cycle();
        for (int n = 0; n < 300; n++) begin
            send_req(random_req(), random_regs());
        end
        random_ready = 1'b1;
        for (int n = 0; n < 300; n++) begin
            send_req(random_req(), random_regs());
        end
        random_ready = 1'b0;
        a_ready      = 1'b1;
        for (int ovr = 0; ovr < 2; ovr++) begin
            send_modrm(8'b00_010_101, SIZE_DWORD, ovr[0]);
            send_modrm(8'b01_011_010, SIZE_DWORD, ovr[0]);
            send_modrm(8'b10_001_100, SIZE_WORD, ovr[0]);
            for (int rm = 4; rm < 8; rm++) begin
                send_modrm({5'b11_000, rm[2:0]}, SIZE_BYTE, ovr[0]);
            end
        end
        req = random_req();
        req.stack_op = 2'b10;
        send_req(req, random_regs());
        req = random_req();
        req.op0.src = SRC_SYS;
        send_req(req, random_regs());
        // filler item that the flush drops
        send_req(random_req(), random_regs());
        // hold the last item, then flush it with a new request waiting
        a_ready = 1'b0;
        req     = random_req();
        regs    = random_regs();
        r_req   = req;
        r_regs  = regs;
        flush   = 1'b1;
        next_cycle();
        flush   = 1'b0;
        a_ready = 1'b1;
        send_req(req, regs);
        random_ready = 1'b1;
        for (int n = 0; n < 100; n++) begin
            send_req(random_req(), random_regs());
        end
        r_valid      = 1'b0;
        random_ready = 1'b0;
        a_ready      = 1'b1;
        waited       = 0;
        while (expected_q.size() != 0 || a_valid) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_timeout("the output to drain");
            end
            next_cycle();
        end
        if (checked > 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("no response was checked");
            $display("Verification failed");
            $fatal(1, "empty run");
        end
    end

endmodule

// File: tb.f
+incdir+testbench
design/agen_pkg.sv
design/reg_size_selector.sv
design/operand_generator.sv
design/agen_stage.sv
design/address_generation_top.sv
testbench/tb_address_generation.sv

// File: Makefile
TOP  := tb_address_generation
SRCS := $(wildcard design/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

all: run

obj_dir/V$(TOP): $(SRCS) tb.f
	verilator --binary -j 0 -f tb.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
